// File: hdl/e100_io_map_pkg.sv
// port map for one clock domain; addresses are full 32-bit matches, with no aliasing
package e100_io_map_pkg;

    // port addresses
    localparam logic [31:0] addr_switch    = 32'h8000_0000;
    localparam logic [31:0] addr_led_red   = 32'h8000_0001;
    localparam logic [31:0] addr_led_green = 32'h8000_0002;
    localparam logic [31:0] addr_hex_lo    = 32'h8000_0003;
    localparam logic [31:0] addr_hex_hi    = 32'h8000_0004;
    localparam logic [31:0] addr_timer     = 32'h8000_0005;

    // port widths
    localparam int switch_width    = 18;
    localparam int led_red_width   = 18;
    localparam int led_green_width = 8;
    localparam int hex_width       = 16;
    localparam int hex_digits      = hex_width / 4;  // one digit per nibble

    // ~8.1 kHz tick from a 50 MHz clock
    localparam int timer_div            = 6144;
    localparam int timer_prescale_width = $clog2(timer_div);

    typedef logic [6:0] seg7_t;  // active low, segment a in bit 0

    // digit 0 shows the least significant nibble
    typedef seg7_t [hex_digits-1:0] hex_digits_t;

    typedef enum logic [2:0] {
        sel_none,
        sel_switch,
        sel_led_red,
        sel_led_green,
        sel_hex_lo,
        sel_hex_hi,
        sel_timer
    } port_sel_e;

endpackage

// File: hdl/e100_bus_pkg.sv
// request and response fields mean something only while valid is high; no back-pressure
package e100_bus_pkg;

    localparam int bus_width = 32;

    typedef logic [bus_width-1:0] word_t;

    // one access from the bus side
    typedef struct packed {
        logic  valid;    // one-cycle strobe
        logic  write;    // 1 = write, 0 = read
        word_t address;
        word_t wdata;
    } io_req_t;

    // read data only, writes are silent
    typedef struct packed {
        logic  valid;
        word_t rdata;
    } io_rsp_t;

    // decoded access between stage 1 and stage 2
    typedef struct packed {
        logic                      valid;
        logic                      write;
        e100_io_map_pkg::port_sel_e sel;
        word_t                     wdata;
    } io_access_t;

endpackage

// File: hdl/io_decode.sv
// stage 1; one cycle of latency, unmapped addresses decode to sel_none and are dropped later
`timescale 1ns/1ps

module io_decode (
    input  logic                     clock,
    input  logic                     rst_n,
    input  e100_bus_pkg::io_req_t    req,
    output e100_bus_pkg::io_access_t access
);

    e100_io_map_pkg::port_sel_e sel;

    // full address compare, nothing outside the map gets through
    always_comb begin
        case (req.address)
            e100_io_map_pkg::addr_switch:    sel = e100_io_map_pkg::sel_switch;
            e100_io_map_pkg::addr_led_red:   sel = e100_io_map_pkg::sel_led_red;
            e100_io_map_pkg::addr_led_green: sel = e100_io_map_pkg::sel_led_green;
            e100_io_map_pkg::addr_hex_lo:    sel = e100_io_map_pkg::sel_hex_lo;
            e100_io_map_pkg::addr_hex_hi:    sel = e100_io_map_pkg::sel_hex_hi;
            e100_io_map_pkg::addr_timer:     sel = e100_io_map_pkg::sel_timer;
            default:                         sel = e100_io_map_pkg::sel_none;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            access.valid <= 1'b0;
        end else begin
            access.valid <= req.valid;
        end
        access.write <= req.write;  // payload, qualified by valid
        access.sel   <= sel;
        access.wdata <= req.wdata;
    end

endmodule

// File: hdl/tick_timer.sv
// free-running and wraps at 2^32 ticks; count is floor(cycles out of reset / timer_div)
`timescale 1ns/1ps

module tick_timer (
    input  logic                clock,
    input  logic                rst_n,
    output e100_bus_pkg::word_t count
);

    logic [e100_io_map_pkg::timer_prescale_width-1:0] prescale;
    logic                                             tick;

    assign tick = (prescale ==
                   e100_io_map_pkg::timer_prescale_width'(e100_io_map_pkg::timer_div - 1));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            prescale <= '0;
            count    <= '0;
        end else if (tick) begin
            prescale <= '0;
            count    <= count + 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

// File: hdl/port_bank.sv
// stage 2; sw is asynchronous and gets two flops, read data is zero-extended to 32 bits
`timescale 1ns/1ps

module port_bank (
    input  logic                                          clock,
    input  logic                                          rst_n,
    input  e100_bus_pkg::io_access_t                      access,
    input  logic [e100_io_map_pkg::switch_width-1:0]      sw,
    input  e100_bus_pkg::word_t                           timer_count,
    output e100_bus_pkg::io_rsp_t                         rsp,
    output logic [e100_io_map_pkg::led_red_width-1:0]     led_red,
    output logic [e100_io_map_pkg::led_green_width-1:0]   led_green,
    output logic [e100_io_map_pkg::hex_width-1:0]         hex_lo_value,
    output logic [e100_io_map_pkg::hex_width-1:0]         hex_hi_value
);

    logic [e100_io_map_pkg::switch_width-1:0] sw_meta;
    logic [e100_io_map_pkg::switch_width-1:0] sw_sync;
    logic                                     wr;
    e100_bus_pkg::word_t                      rd_data;

    assign wr = access.valid & access.write;

    // two-flop synchronizer
    always_ff @(posedge clock) begin
        sw_meta <= sw;
        sw_sync <= sw_meta;
    end

    // output ports keep the low bits of wdata
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            led_red      <= '0;
            led_green    <= '0;
            hex_lo_value <= '0;
            hex_hi_value <= '0;
        end else if (wr) begin
            case (access.sel)
                e100_io_map_pkg::sel_led_red:
                    led_red <= access.wdata[e100_io_map_pkg::led_red_width-1:0];
                e100_io_map_pkg::sel_led_green:
                    led_green <= access.wdata[e100_io_map_pkg::led_green_width-1:0];
                e100_io_map_pkg::sel_hex_lo:
                    hex_lo_value <= access.wdata[e100_io_map_pkg::hex_width-1:0];
                e100_io_map_pkg::sel_hex_hi:
                    hex_hi_value <= access.wdata[e100_io_map_pkg::hex_width-1:0];
                default: ;  // switch, timer and unmapped ignore writes
            endcase
        end
    end

    // read mux, zero above the port width
    always_comb begin
        rd_data = '0;
        case (access.sel)
            e100_io_map_pkg::sel_switch:    rd_data[$bits(sw_sync)-1:0] = sw_sync;
            e100_io_map_pkg::sel_led_red:   rd_data[$bits(led_red)-1:0] = led_red;
            e100_io_map_pkg::sel_led_green: rd_data[$bits(led_green)-1:0] = led_green;
            e100_io_map_pkg::sel_hex_lo:    rd_data[$bits(hex_lo_value)-1:0] = hex_lo_value;
            e100_io_map_pkg::sel_hex_hi:    rd_data[$bits(hex_hi_value)-1:0] = hex_hi_value;
            e100_io_map_pkg::sel_timer:     rd_data = timer_count;
            default:                        rd_data = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= access.valid & ~access.write;  // one pulse per read
        end
        rsp.rdata <= rd_data;
    end

endmodule

// File: hdl/hex_display.sv
// stage 3; one cycle of latency, digits are active low for a common-anode display
`timescale 1ns/1ps

module hex_display (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic [e100_io_map_pkg::hex_width-1:0] value,
    output e100_io_map_pkg::hex_digits_t         digits
);

    // segment a in bit 0 .. g in bit 6, 0 lights the segment
    function automatic e100_io_map_pkg::seg7_t seg_of(input logic [3:0] nibble);
        case (nibble)
            4'h0: seg_of = 7'b1000000;
            4'h1: seg_of = 7'b1111001;
            4'h2: seg_of = 7'b0100100;
            4'h3: seg_of = 7'b0110000;
            4'h4: seg_of = 7'b0011001;
            4'h5: seg_of = 7'b0010010;
            4'h6: seg_of = 7'b0000010;
            4'h7: seg_of = 7'b1111000;
            4'h8: seg_of = 7'b0000000;
            4'h9: seg_of = 7'b0010000;
            4'ha: seg_of = 7'b0001000;
            4'hb: seg_of = 7'b0000011;
            4'hc: seg_of = 7'b1000110;
            4'hd: seg_of = 7'b0100001;
            4'he: seg_of = 7'b0000110;
            default: seg_of = 7'b0001110;  // F
        endcase
    endfunction

    always_ff @(posedge clock) begin
        for (int i = 0; i < e100_io_map_pkg::hex_digits; i++) begin
            if (!rst_n) begin
                digits[i] <= seg_of(4'h0);  // blank value shows 0
            end else begin
                digits[i] <= seg_of(value[4*i +: 4]);
            end
        end
    end

endmodule

// File: hdl/e100_io_top.sv
// read latency is 2 cycles, LEDs update 1 cycle after the write edge and hex digits after 2
`timescale 1ns/1ps

module e100_io_top (
    input  logic                                        clock,
    input  logic                                        rst_n,
    input  e100_bus_pkg::io_req_t                       req,
    input  logic [e100_io_map_pkg::switch_width-1:0]    sw,
    output e100_bus_pkg::io_rsp_t                       rsp,
    output logic [e100_io_map_pkg::led_red_width-1:0]   led_red,
    output logic [e100_io_map_pkg::led_green_width-1:0] led_green,
    output e100_io_map_pkg::hex_digits_t                hex_lo,
    output e100_io_map_pkg::hex_digits_t                hex_hi
);

    e100_bus_pkg::io_access_t                 access;
    e100_bus_pkg::word_t                      timer_count;
    logic [e100_io_map_pkg::hex_width-1:0]    hex_lo_value;
    logic [e100_io_map_pkg::hex_width-1:0]    hex_hi_value;

    io_decode io_decode_inst (
        .clock  (clock),
        .rst_n  (rst_n),
        .req    (req),
        .access (access)
    );

    tick_timer tick_timer_inst (
        .clock (clock),
        .rst_n (rst_n),
        .count (timer_count)
    );

    port_bank port_bank_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .access       (access),
        .sw           (sw),
        .timer_count  (timer_count),
        .rsp          (rsp),
        .led_red      (led_red),
        .led_green    (led_green),
        .hex_lo_value (hex_lo_value),
        .hex_hi_value (hex_hi_value)
    );

    // HEX3-HEX0
    hex_display hex_lo_inst (
        .clock  (clock),
        .rst_n  (rst_n),
        .value  (hex_lo_value),
        .digits (hex_lo)
    );

    // HEX7-HEX4
    hex_display hex_hi_inst (
        .clock  (clock),
        .rst_n  (rst_n),
        .value  (hex_hi_value),
        .digits (hex_hi)
    );

endmodule

// File: sim/clock_gen.sv
// free-running testbench clock, starts low; period in ns
`timescale 1ns/1ps

module clock_gen #(
    parameter int period_ns = 40
) (
    output logic clock
);

    initial clock = 1'b0;

    always #(period_ns / 2) clock = ~clock;

endmodule

// File: sim/e100_io_chk.sv
// bound to e100_io_top; assumes the 2-cycle read latency and a reset held for several cycles
`timescale 1ns/1ps

module e100_io_chk (
    input logic                                        clock,
    input logic                                        rst_n,
    input e100_bus_pkg::io_req_t                       req,
    input e100_bus_pkg::io_rsp_t                       rsp,
    input logic [e100_io_map_pkg::led_red_width-1:0]   led_red,
    input logic [e100_io_map_pkg::led_green_width-1:0] led_green
);

    // every read answers exactly two edges later
    assert property (@(posedge clock) disable iff (!rst_n)
        (req.valid && !req.write) |-> ##2 rsp.valid)
        else $error("read request got no response two cycles later");

    assert property (@(posedge clock) disable iff (!rst_n)
        rsp.valid |-> $past(req.valid && !req.write, 2))
        else $error("response without a read two cycles earlier");

    // leds cleared by the synchronous reset
    assert property (@(posedge clock)
        !rst_n |=> (led_red == '0 && led_green == '0))
        else $error("led outputs not zero during reset");

endmodule

bind e100_io_top e100_io_chk e100_io_chk_inst (
    .clock     (clock),
    .rst_n     (rst_n),
    .req       (req),
    .rsp       (rsp),
    .led_red   (led_red),
    .led_green (led_green)
);

// File: sim/tb_e100_io.sv
// drives on the falling edge and compares on the rising edge; timer reads allow one tick of slack
`timescale 1ns/1ps

module tb_e100_io;

    localparam int reset_cycles = 16;
    localparam int num_trans    = 80;  // upper bound on requests issued
    localparam int limit_cycles = reset_cycles + num_trans * 8 + 4 * e100_io_map_pkg::timer_div;

    logic                                        clock;
    logic                                        rst_n;
    e100_bus_pkg::io_req_t                       req;
    logic [e100_io_map_pkg::switch_width-1:0]    sw;
    e100_bus_pkg::io_rsp_t                       rsp;
    logic [e100_io_map_pkg::led_red_width-1:0]   led_red;
    logic [e100_io_map_pkg::led_green_width-1:0] led_green;
    e100_io_map_pkg::hex_digits_t                hex_lo;
    e100_io_map_pkg::hex_digits_t                hex_hi;

    // port map model
    logic [17:0] m_led_red;
    logic [7:0]  m_led_green;
    logic [15:0] m_hex_lo;
    logic [15:0] m_hex_hi;

    logic [31:0] exp_q[$];
    string       name_q[$];
    bit          timer_q[$];
    logic [15:0] lfsr_state;
    int          errors = 0;
    int          cycles = 0;  // rising edges with rst_n high
    logic [31:0] port_addr [6] = '{32'h8000_0000, 32'h8000_0001, 32'h8000_0002,
                                   32'h8000_0003, 32'h8000_0004, 32'h8000_0005};

    clock_gen #(.period_ns(40)) clock_gen_inst (.clock(clock));

    e100_io_top e100_io_top_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .req       (req),
        .sw        (sw),
        .rsp       (rsp),
        .led_red   (led_red),
        .led_green (led_green),
        .hex_lo    (hex_lo),
        .hex_hi    (hex_hi)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // active low with segment a in bit 0
    function automatic logic [6:0] ref_seg(input logic [3:0] n);
        case (n)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    // timer reads are worked out at response time
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        case (addr)
            32'h8000_0000: return 32'(sw);
            32'h8000_0001: return 32'(m_led_red);
            32'h8000_0002: return 32'(m_led_green);
            32'h8000_0003: return 32'(m_hex_lo);
            32'h8000_0004: return 32'(m_hex_hi);
            default:       return 32'h0;
        endcase
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
        case (addr)
            32'h8000_0001: m_led_red = data[17:0];
            32'h8000_0002: m_led_green = data[7:0];
            32'h8000_0003: m_hex_lo = data[15:0];
            32'h8000_0004: m_hex_hi = data[15:0];
            default: ;
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic send(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                        input string name);
        @(negedge clock);
        req.valid   = 1'b1;
        req.write   = wr;
        req.address = addr;
        req.wdata   = data;
        if (wr) begin
            model_write(addr, data);
        end else begin
            exp_q.push_back(ref_read(addr));
            name_q.push_back(name);
            timer_q.push_back(addr == e100_io_map_pkg::addr_timer);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clock);
            req.valid = 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) @(negedge clock);
    endtask

    // hex digits settle two edges after the write
    task automatic check_outputs(input string name);
        idle(3);
        check_value({name, "_led_red"}, 32'(m_led_red), 32'(led_red));
        check_value({name, "_led_green"}, 32'(m_led_green), 32'(led_green));
        for (int i = 0; i < 4; i++) begin
            check_value({name, "_hex_lo"}, 32'(ref_seg(m_hex_lo[4*i +: 4])), 32'(hex_lo[i]));
            check_value({name, "_hex_hi"}, 32'(ref_seg(m_hex_hi[4*i +: 4])), 32'(hex_hi[i]));
        end
    endtask

    always @(posedge clock) begin
        if (rst_n) cycles <= cycles + 1;
    end

    always @(posedge clock) begin : compare_rsp
        logic [31:0] expected;
        string       name;
        bit          is_timer;
        if (rst_n && rsp.valid) begin
            if (exp_q.size() == 0) begin
                $display("read response arrived with no read outstanding");
                errors++;
            end else begin
                expected = exp_q.pop_front();
                name     = name_q.pop_front();
                is_timer = timer_q.pop_front();
                if (is_timer) begin
                    expected = (cycles - 2) / e100_io_map_pkg::timer_div;
                    if (rsp.rdata == expected + 1) expected = expected + 1;
                end
                check_value(name, expected, rsp.rdata);
            end
        end
    end

    initial begin : watchdog
        repeat (limit_cycles) @(posedge clock);
        $display("run timed out after %0d cycles", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        req         = '0;
        sw          = '0;
        rst_n       = 1'b0;
        m_led_red   = '0;
        m_led_green = '0;
        m_hex_lo    = '0;
        m_hex_hi    = '0;
        lfsr_state  = 16'd90;
        repeat (reset_cycles) @(negedge clock);
        rst_n = 1'b1;
        sw    = 18'(rand_bits(18));

        check_outputs("reset_state");
        for (int p = 0; p < 6; p++) send(1'b0, port_addr[p], 32'h0, "reset_read");
        drain();

        for (int r = 0; r < 4; r++) begin
            for (int p = 1; p < 5; p++) send(1'b1, port_addr[p], rand_bits(32), "write");
            check_outputs("write_outputs");
            for (int p = 1; p < 5; p++) send(1'b0, port_addr[p], 32'h0, "readback");
            drain();
        end

        // every nibble value reaches hex_lo once
        for (int r = 0; r < 4; r++) begin
            send(1'b1, e100_io_map_pkg::addr_hex_lo, 32'h3210 + r * 32'h4444, "seg_lo");
            send(1'b1, e100_io_map_pkg::addr_hex_hi, rand_bits(16), "seg_hi");
            check_outputs("seven_segment");
        end

        for (int r = 0; r < 2; r++) begin
            @(negedge clock);
            sw = 18'(rand_bits(18));
            idle(3);  // through the synchronizer
            send(1'b0, e100_io_map_pkg::addr_switch, 32'h0, "pipe_switch");
            for (int p = 1; p < 5; p++) send(1'b0, port_addr[p], 32'h0, "pipe_port");
            send(1'b0, e100_io_map_pkg::addr_switch, 32'h0, "pipe_switch_again");
            drain();
        end

        send(1'b1, e100_io_map_pkg::addr_switch, rand_bits(32), "wr_switch");
        send(1'b1, e100_io_map_pkg::addr_timer, rand_bits(32), "wr_timer");
        send(1'b1, 32'h8000_0006, rand_bits(32), "wr_unmapped");
        send(1'b1, 32'h0000_0001, rand_bits(32), "wr_unmapped_low");
        check_outputs("ignored_writes");
        send(1'b0, 32'h8000_0006, 32'h0, "rd_unmapped");
        send(1'b0, 32'h0000_0003, 32'h0, "rd_unmapped_low");
        send(1'b0, 32'hffff_ffff, 32'h0, "rd_unmapped_top");
        drain();

        send(1'b0, e100_io_map_pkg::addr_timer, 32'h0, "timer_early");
        drain();
        repeat (e100_io_map_pkg::timer_div + 37) @(negedge clock);
        send(1'b0, e100_io_map_pkg::addr_timer, 32'h0, "timer_one");
        drain();
        repeat (e100_io_map_pkg::timer_div + e100_io_map_pkg::timer_div / 2) @(negedge clock);
        send(1'b0, e100_io_map_pkg::addr_timer, 32'h0, "timer_later");
        drain();

        idle(2);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/e100_io_map_pkg.sv
hdl/e100_bus_pkg.sv
hdl/io_decode.sv
hdl/tick_timer.sv
hdl/port_bank.sv
hdl/hex_display.sv
hdl/e100_io_top.sv
sim/clock_gen.sv
sim/e100_io_chk.sv
sim/tb_e100_io.sv

// File: Bender.yml
package:
  name: e100_io

sources:
  - hdl/e100_io_map_pkg.sv
  - hdl/e100_bus_pkg.sv
  - hdl/io_decode.sv
  - hdl/tick_timer.sv
  - hdl/port_bank.sv
  - hdl/hex_display.sv
  - hdl/e100_io_top.sv
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/e100_io_chk.sv
      - sim/tb_e100_io.sv
